/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := vector_lane_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status of the simulation is the test result
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
hw/lane_cfg_pkg.sv
hw/lane_types_pkg.sv
hw/arithmetic_unit.sv
hw/multiply_unit.sv
hw/divide_unit.sv
hw/vector_lane.sv
hw/result_queue.sv
hw/writeback_stage.sv
hw/vector_lane_top.sv
testbench/vector_lane_tb.sv

/* hw/arithmetic_unit.sv */
module arithmetic_unit (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         start,
  input  lane_types_pkg::lane_op_t     op,
  output logic                         valid,
  output lane_types_pkg::lane_result_t result
);

  import lane_types_pkg::*;

  elem_t   alu_out;
  alu_op_e eff_op;   // sub-op actually used

  // reductions always add
  assign eff_op = (op.fu_type == RED) ? ADD : op.alu_op;

  always_comb begin
    case (eff_op)
      ADD:     alu_out = op.a + op.b;
      SUB:     alu_out = op.a - op.b;
      AND:     alu_out = op.a & op.b;
      OR:      alu_out = op.a | op.b;
      XOR:     alu_out = op.a ^ op.b;
      default: alu_out = '0;  // unused encodings
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid <= 1'b0;
    end else begin
      valid <= start;  // one cycle latency
    end
  end

  // result payload, loaded on start only
  always_ff @(posedge CLK) begin
    if (start) begin
      result.value     <= alu_out;
      result.tag       <= op.tag;
      result.exception <= 1'b0;   // alu never traps
      result.red       <= (op.fu_type == RED);
      result.last      <= op.last;
    end
  end

  // a decoded start needs a clean unit type from the issuer
  start_known_type: assert property (@(posedge CLK) disable iff (!nRST)
    start |-> !$isunknown(op.fu_type))
    else $error("arithmetic_unit started with unknown fu_type");

endmodule

/* hw/divide_unit.sv */
module divide_unit (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         start,
  input  lane_types_pkg::lane_op_t     op,
  output logic                         valid,
  output lane_types_pkg::lane_result_t result,
  output logic                         busy
);

  import lane_cfg_pkg::*;
  import lane_types_pkg::*;

  localparam int CNT_W = $clog2(DIV_ITERS);

  div_state_e       state;
  logic [CNT_W-1:0] cnt;         // iteration count
  elem_t            divisor;
  elem_t            rem;         // partial remainder
  elem_t            quo;         // dividend shifts out, quotient shifts in
  tag_t             tag_q;
  logic             last_q;
  logic             div_zero;
  logic [ELEM_W:0]  rem_shift;   // remainder with next dividend bit
  logic [ELEM_W:0]  trial;       // rem_shift - divisor

  always_comb begin
    rem_shift = {rem, quo[ELEM_W-1]};
    trial     = rem_shift - {1'b0, divisor};
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: if (start) begin
          state <= RUN;
          cnt   <= '0;
        end
        RUN: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(DIV_ITERS - 1)) state <= DONE;  // last bit
        end
        DONE:    state <= IDLE;  // valid shown for one cycle
        default: state <= IDLE;
      endcase
    end
  end

  // datapath, no reset needed
  always_ff @(posedge CLK) begin
    if (state == IDLE && start) begin
      rem      <= '0;
      quo      <= op.a;
      divisor  <= op.b;
      div_zero <= (op.b == '0);
      tag_q    <= op.tag;
      last_q   <= op.last;
    end else if (state == RUN) begin
      if (!trial[ELEM_W]) begin  // fits, keep difference
        rem <= trial[ELEM_W-1:0];
        quo <= {quo[ELEM_W-2:0], 1'b1};
      end else begin             // restore
        rem <= rem_shift[ELEM_W-1:0];
        quo <= {quo[ELEM_W-2:0], 1'b0};
      end
    end
  end

  assign valid            = (state == DONE);
  assign busy             = (state != IDLE);
  assign result.value     = div_zero ? '1 : quo;  // all ones on /0
  assign result.tag       = tag_q;
  assign result.exception = div_zero;
  assign result.red       = 1'b0;
  assign result.last      = last_q;

  // lane must hold off new divides until this one retires
  no_start_busy: assert property (@(posedge CLK) disable iff (!nRST)
    start |-> !busy)
    else $error("divide_unit started while busy");

  // each valid belongs to the start seen DIV_ITERS + 1 edges back
  valid_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
    valid |-> $past(start, DIV_ITERS + 1))
    else $error("divide_unit valid out of step with its start");

endmodule

/* hw/lane_cfg_pkg.sv */
package lane_cfg_pkg;

  // datapath widths
  localparam int ELEM_W = 32;  // one vector element
  localparam int TAG_W  = 4;   // op tag, travels with the result

  // unit latencies
  localparam int MUL_STAGES = 2;   // multiplier pipeline depth
  localparam int DIV_ITERS  = 32;  // one quotient bit per cycle

  // result buffer between lane and writeback
  localparam int QUEUE_DEPTH = 4;

endpackage

/* hw/lane_types_pkg.sv */
package lane_types_pkg;

  typedef logic [lane_cfg_pkg::ELEM_W-1:0] elem_t;  // one element
  typedef logic [lane_cfg_pkg::TAG_W-1:0]  tag_t;   // op tag

  // which unit takes the op
  typedef enum logic [2:0] {
    ARITH,  // plain alu element
    RED,    // reduction element, alu add
    MUL,    // low half of a*b
    MADD,   // a*b + c
    DIV     // unsigned a/b
  } fu_type_e;

  // alu sub-op, ignored outside ARITH
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR
  } alu_op_e;

  // divider fsm
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } div_state_e;

  // one element op as issued to the lane
  typedef struct packed {
    fu_type_e fu_type;
    alu_op_e  alu_op;
    elem_t    a;
    elem_t    b;
    elem_t    c;      // addend, MADD only
    tag_t     tag;
    logic     last;   // closes a reduction
  } lane_op_t;

  // completed element
  typedef struct packed {
    elem_t value;
    tag_t  tag;
    logic  exception;  // divide by zero
    logic  red;        // fold into the running sum
    logic  last;
  } lane_result_t;

endpackage

/* hw/multiply_unit.sv */
module multiply_unit (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         start,
  input  lane_types_pkg::lane_op_t     op,
  output logic                         valid,
  output lane_types_pkg::lane_result_t result,
  output logic                         in_flight
);

  import lane_types_pkg::*;

  // stage one registers
  logic  s1_valid;
  elem_t s1_prod;   // low half of a*b
  elem_t s1_c;
  tag_t  s1_tag;
  logic  s1_madd;
  logic  s1_last;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      s1_valid <= 1'b0;
      valid    <= 1'b0;
    end else begin
      s1_valid <= start;
      valid    <= s1_valid;  // stage two
    end
  end

  // stage one payload
  always_ff @(posedge CLK) begin
    if (start) begin
      s1_prod <= op.a * op.b;  // truncated to ELEM_W
      s1_c    <= op.c;
      s1_tag  <= op.tag;
      s1_madd <= (op.fu_type == MADD);
      s1_last <= op.last;
    end
  end

  // stage two payload, add c for multiply-add
  always_ff @(posedge CLK) begin
    if (s1_valid) begin
      result.value     <= s1_madd ? s1_prod + s1_c : s1_prod;
      result.tag       <= s1_tag;
      result.exception <= 1'b0;
      result.red       <= 1'b0;
      result.last      <= s1_last;
    end
  end

  assign in_flight = s1_valid | valid;  // either stage occupied

endmodule

/* hw/result_queue.sv */
module result_queue (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         push,
  input  lane_types_pkg::lane_result_t din,
  input  logic                         pop,
  output lane_types_pkg::lane_result_t head,
  output logic                         empty,
  output logic                         near_full
);

  import lane_cfg_pkg::*;
  import lane_types_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = PTR_W + 1;
  // room kept for multiplies already in the pipe
  localparam int NEAR_LVL = QUEUE_DEPTH - MUL_STAGES - 1;

  lane_result_t     mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wptr, rptr;
  logic [CNT_W-1:0] count;
  logic             full;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) wptr <= wptr + 1'b1;  // wraps at depth
      if (pop)  rptr <= rptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (push) mem[wptr] <= din;
  end

  assign head      = mem[rptr];
  assign empty     = (count == '0);
  assign full      = (count == CNT_W'(QUEUE_DEPTH));
  assign near_full = (count > CNT_W'(NEAR_LVL));  // fewer than 3 free

  // busy and drain gating upstream must keep these from happening
  no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
    !(push && full && !pop) && !(pop && empty))
    else $error("result_queue overflow or underflow");

endmodule

/* hw/vector_lane.sv */
module vector_lane (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         issue,
  input  lane_types_pkg::lane_op_t     op,
  output logic                         res_valid,
  output lane_types_pkg::lane_result_t res,
  output logic                         busy,
  output logic                         mul_wait
);

  import lane_types_pkg::*;

  logic         is_arith, is_mul, is_div;
  logic         start_a, start_m;
  logic         div_start;   // registered, DIV begins one cycle late
  lane_op_t     div_op;      // op held for the late start
  logic         valid_a, valid_m, valid_d;
  lane_result_t res_a, res_m, res_d;
  logic         mul_in_flight;
  logic         div_busy;

  // unit decode
  assign is_arith = (op.fu_type == ARITH) || (op.fu_type == RED);
  assign is_mul   = (op.fu_type == MUL) || (op.fu_type == MADD);
  assign is_div   = (op.fu_type == DIV);

  assign start_a = issue && is_arith;
  assign start_m = issue && is_mul;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      div_start <= 1'b0;
    end else begin
      div_start <= issue && is_div;  // one-cycle strobe
    end
  end

  always_ff @(posedge CLK) begin
    if (issue && is_div) div_op <= op;  // operands for the divider
  end

  arithmetic_unit arithmetic_unit_i (
    .CLK    (CLK),
    .nRST   (nRST),
    .start  (start_a),
    .op     (op),
    .valid  (valid_a),
    .result (res_a)
  );

  multiply_unit multiply_unit_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .start     (start_m),
    .op        (op),
    .valid     (valid_m),
    .result    (res_m),
    .in_flight (mul_in_flight)
  );

  divide_unit divide_unit_i (
    .CLK    (CLK),
    .nRST   (nRST),
    .start  (div_start),
    .op     (div_op),
    .valid  (valid_d),
    .result (res_d),
    .busy   (div_busy)
  );

  // at most one unit finishes per cycle, so a plain select is enough
  always_comb begin
    if (valid_m)      res = res_m;
    else if (valid_d) res = res_d;
    else              res = res_a;
  end

  assign res_valid = valid_a | valid_m | valid_d;
  assign mul_wait  = mul_in_flight;
  // pending divide start counts too, else an alu op slips in behind it
  assign busy      = div_start | div_busy | mul_in_flight;

  one_result: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({valid_a, valid_m, valid_d}))
    else $error("vector_lane result collision");

endmodule

/* hw/vector_lane_top.sv */
module vector_lane_top (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         issue,
  input  lane_types_pkg::lane_op_t     op,
  input  logic                         drain,
  output logic                         busy,
  output logic                         mul_wait,
  output logic                         out_valid,
  output lane_types_pkg::lane_result_t out_result
);

  import lane_types_pkg::*;

  logic         res_valid;
  lane_result_t res;
  logic         lane_busy;
  logic         q_pop, q_empty, q_near_full;
  lane_result_t q_head;

  vector_lane vector_lane_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .issue     (issue),
    .op        (op),
    .res_valid (res_valid),
    .res       (res),
    .busy      (lane_busy),
    .mul_wait  (mul_wait)
  );

  result_queue result_queue_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .push      (res_valid),
    .din       (res),
    .pop       (q_pop),
    .head      (q_head),
    .empty     (q_empty),
    .near_full (q_near_full)
  );

  writeback_stage writeback_stage_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .drain      (drain),
    .empty      (q_empty),
    .head       (q_head),
    .pop        (q_pop),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

  assign busy = lane_busy | q_near_full;  // back-pressure from the queue

endmodule

/* hw/writeback_stage.sv */
module writeback_stage (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         drain,
  input  logic                         empty,
  input  lane_types_pkg::lane_result_t head,
  output logic                         pop,
  output logic                         out_valid,
  output lane_types_pkg::lane_result_t out_result
);

  import lane_types_pkg::*;

  elem_t acc;      // running reduction sum
  elem_t red_sum;  // sum including the head element

  assign pop     = drain && !empty;
  assign red_sum = acc + head.value;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
      acc       <= '0;
    end else begin
      out_valid <= pop;
      if (pop && head.red) begin
        acc <= head.last ? '0 : red_sum;  // restart after last
      end
    end
  end

  // output payload
  always_ff @(posedge CLK) begin
    if (pop) begin
      out_result <= head;
      if (head.red) out_result.value <= red_sum;  // emit sum so far
    end
  end

endmodule

/* testbench/lane_tests.txt */
# fu alu_op a b c tag last expected exception (a b c tag expected in hex)
# fu 0 ARITH 1 RED 2 MUL 3 MADD 4 DIV, alu_op 0 ADD 1 SUB 2 AND 3 OR 4 XOR
0 0 00000005 00000003 00000000 0 0 00000008 0
0 1 00000003 00000005 00000000 1 0 fffffffe 0
0 2 f0f0f0f0 0ff00ff0 00000000 2 0 00f000f0 0
0 3 f0f0f0f0 0ff00ff0 00000000 3 0 fff0fff0 0
0 4 f0f0f0f0 0ff00ff0 00000000 4 0 ff00ff00 0
2 0 00001234 00000010 00000000 5 0 00012340 0
2 0 80000001 00000003 00000000 6 0 80000003 0
3 0 00000007 00000006 00000010 7 0 0000003a 0
2 0 ffffffff ffffffff 00000000 8 0 00000001 0
3 0 00010000 00010000 00000005 9 0 00000005 0
4 0 00000064 00000007 00000000 a 0 0000000e 0
4 0 ffffffff 00000010 00000000 b 0 0fffffff 0
4 0 00001234 00000000 00000000 c 0 ffffffff 1
1 0 00000005 00000005 00000000 d 0 0000000a 0
1 0 00000003 00000004 00000000 e 0 00000011 0
1 0 00000100 00000000 00000000 f 1 00000111 0
1 0 00000002 00000001 00000000 0 0 00000003 0
1 0 fffffffe 00000000 00000000 1 1 00000001 0
0 0 00000001 00000001 00000000 2 0 00000002 0
0 4 12345678 ffffffff 00000000 3 0 edcba987 0
0 1 00000000 00000001 00000000 4 0 ffffffff 0
2 0 00000003 00000003 00000000 5 0 00000009 0
4 0 00000009 00000003 00000000 6 0 00000003 0
0 3 00000a00 000000b0 00000000 7 0 00000ab0 0
1 0 00000007 00000001 00000000 8 1 00000008 0
0 0 7fffffff 00000001 00000000 9 0 80000000 0

/* testbench/vector_lane_tb.sv */
module vector_lane_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import lane_cfg_pkg::*;
  import lane_types_pkg::*;

  localparam int    MAX_TESTS = 64;
  localparam string TEST_FILE = "testbench/lane_tests.txt";
  // longest a result may take once issuing stops and drain is high
  localparam int    SETTLE_CYCLES = DIV_ITERS + QUEUE_DEPTH + 8;

  // what one output element should look like
  typedef struct packed {
    elem_t value;
    tag_t  tag;
    logic  exception;
    logic  red;
    logic  last;
  } expect_t;

  logic         CLK;
  logic         nRST;
  logic         issue;
  lane_op_t     op;
  logic         drain;
  logic         busy;
  logic         mul_wait;
  logic         out_valid;
  lane_result_t out_result;

  lane_op_t tests_op [MAX_TESTS];  // one op per data line
  expect_t  expected [MAX_TESTS];
  expect_t  expq [$];              // outstanding results, issue order
  expect_t  head_exp;

  int   num_tests;
  int   win_lo;          // first test issued with drain toggling
  int   idx;
  int   issued;
  int   received;
  int   cycles;
  int   cycle_limit;
  int   settle;
  int   rnd;
  logic in_window;
  logic mul_line;
  logic div_wait;        // divider holds busy
  logic saw_backpressure;

  vector_lane_top vector_lane_top_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .issue      (issue),
    .op         (op),
    .drain      (drain),
    .busy       (busy),
    .mul_wait   (mul_wait),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;  // 10 ns period
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, want);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          n;
    int          fu, sub, lst, exc;
    logic [31:0] a, b, c, ev;
    logic [3:0]  tg;
    string       line;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) abort_run("cannot open the test data file");
    num_tests = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;  // blank or comment
      n = $sscanf(line, "%d %d %h %h %h %h %d %h %d",
                  fu, sub, a, b, c, tg, lst, ev, exc);
      if (n != 9) abort_run("malformed line in the test data file");
      if (num_tests == MAX_TESTS) abort_run("too many lines in the test data file");
      tests_op[num_tests].fu_type = fu_type_e'(fu[2:0]);
      tests_op[num_tests].alu_op  = alu_op_e'(sub[2:0]);
      tests_op[num_tests].a       = a;
      tests_op[num_tests].b       = b;
      tests_op[num_tests].c       = c;
      tests_op[num_tests].tag     = tg;
      tests_op[num_tests].last    = lst[0];
      // reduction elements come back marked, last passes through every unit
      expected[num_tests]         = '{value: ev, tag: tg, exception: exc[0],
                                      red: (tests_op[num_tests].fu_type == RED),
                                      last: lst[0]};
      num_tests++;
    end
    $fclose(fd);
    cycle_limit = 40 * num_tests + 200;
    win_lo      = num_tests * 2 / 3;  // last third runs under back-pressure
  endtask

  // one clock, inputs change 1 ns after the edge
  task automatic step_cycle();
    @(posedge CLK);
    #1;
    issue = 1'b0;
    if (in_window) drain = ($urandom % 4) == 0;  // mostly low
    else drain = 1'b1;
    // only the queue can raise busy here
    if (in_window && !drain && busy && !mul_wait && !div_wait) saw_backpressure = 1'b1;
  endtask

  // watchdog
  always @(posedge CLK) begin
    cycles++;
    if (cycles > cycle_limit) abort_run("timeout, results stopped arriving");
  end

  // outputs are registered, look at them mid-cycle
  always @(negedge CLK) begin
    if (nRST && out_valid) begin
      if (expq.size() == 0) begin
        abort_run("out_valid with no result outstanding");
      end else begin
        head_exp = expq.pop_front();
        check_value("out_result.value", out_result.value, head_exp.value);
        check_value("out_result.tag", 32'(out_result.tag), 32'(head_exp.tag));
        check_value("out_result.exception", 32'(out_result.exception),
                    32'(head_exp.exception));
        check_value("out_result.red", 32'(out_result.red), 32'(head_exp.red));
        check_value("out_result.last", 32'(out_result.last), 32'(head_exp.last));
        received++;
      end
    end
  end

  initial begin
    rnd              = $urandom(33);
    nRST             = 1'b0;
    issue            = 1'b0;
    op               = '0;
    drain            = 1'b1;
    in_window        = 1'b0;
    div_wait         = 1'b0;
    saw_backpressure = 1'b0;
    issued           = 0;
    received         = 0;
    cycles           = 0;
    settle           = 0;
    cycle_limit      = 1000;
    load_tests();
    repeat (16) @(posedge CLK);
    #1 nRST = 1'b1;

    // idle after reset
    repeat (2) step_cycle();
    check_value("out_valid", 32'(out_valid), 32'd0);
    check_value("busy", 32'(busy), 32'd0);
    check_value("mul_wait", 32'(mul_wait), 32'd0);

    idx = 0;
    while (idx < num_tests) begin
      in_window = (idx >= win_lo);
      step_cycle();
      mul_line = tests_op[idx].fu_type inside {MUL, MADD};
      // multiplies may follow each other while only the pipe is busy
      if (!busy || (mul_wait && mul_line && !in_window)) begin
        issue = 1'b1;
        op    = tests_op[idx];
        expq.push_back(expected[idx]);
        issued++;
        idx++;
        if (op.fu_type == DIV) begin
          div_wait = 1'b1;
          repeat (DIV_ITERS + 2) begin  // start reg, iterations, done
            step_cycle();
            check_value("busy", 32'(busy), 32'd1);
          end
          div_wait = 1'b0;
        end
      end
    end

    in_window = 1'b0;  // drain high from here on
    while (expq.size() != 0 && settle < SETTLE_CYCLES) begin
      step_cycle();
      settle++;
    end
    repeat (8) step_cycle();  // catch stray outputs
    check_value("busy_under_backpressure", 32'(saw_backpressure), 32'd1);

    if (received < issued) begin
      abort_run("fewer results arrived than were issued");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule
